//--- capture_top.f
+incdir+design
design/capture_pkg.sv
design/dac_cmd_if.sv
design/cmd_decoder.sv
design/axis_channel.sv
design/feedback_select.sv
design/sample_ram.sv
design/data_buffer.sv
design/capture_top.sv
dv/capture_tb.sv

//--- design/axis_channel.sv
// one motor axis
// dac setpoint register and rising-edge detect of adc conversion done

module axis_channel (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        set_wen,
    input  logic [15:0] set_value,
    input  logic        adc_done,
    input  logic [15:0] adc_data,
    output logic [15:0] dac_setpoint,
    output logic        fb_pulse,
    output logic [15:0] fb_sample
);

    logic done_last;    // adc_done one clock back
    logic done_rise;

    assign done_rise = adc_done && !done_last;

    // ---------------------------------------------------------------------------
    // setpoint and edge state
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dac_setpoint <= '0;
            done_last    <= 1'b0;
            fb_pulse     <= 1'b0;
        end else begin
            if (set_wen)
                dac_setpoint <= set_value;
            done_last <= adc_done;
            fb_pulse  <= done_rise;     // single cycle, a held level gives one
        end
    end

    // sample latched in step with fb_pulse
    always_ff @(posedge clk) begin
        if (done_rise)
            fb_sample <= adc_data;
    end

endmodule

//--- design/capture_defines.svh
// bus address map, axis count and capture buffer size
// for the motor-current capture path
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// ---------------------------------------------------------------------------
// bus address map, bits 15:12 select the space
// ---------------------------------------------------------------------------
`define ADDR_MAIN     4'h0      // main register space, axis pages
`define ADDR_DBUF     4'h7      // capture buffer space

// register offset inside an axis page, address bits 3:0
`define OFF_DAC_CTRL  4'h0

// bus axis 0 is the board page, channels sit on bus axes 1..NUM_AXES
`define NUM_AXES      4

// capture buffer depth is 2**BUF_AW entries
`define BUF_AW        10

`endif

//--- design/capture_pkg.sv
// shared types of the capture path
// buffer entry, status word and the read-word union over both

package capture_pkg;

    // bus axis number, address bits 7:4
    typedef logic [3:0] axis_t;

    // one capture buffer entry
    typedef struct packed {
        logic        is_fb;     // 0 command, 1 feedback
        logic        ts_over;   // timestamp wider than 14 bits
        logic [13:0] ts_low;
        logic [15:0] value;     // commanded current or adc sample
    } buf_entry_t;

    // buffer status as read at 0x7800
    typedef struct packed {
        logic [15:0] rsvd;      // always zero
        logic        collecting;
        logic        zero;
        axis_t       chan;
        logic [9:0]  wr_addr;
    } status_word_t;

    // the single read data word, meaning depends on the address
    typedef union packed {
        buf_entry_t   entry;
        status_word_t status;
    } read_word_u;

endpackage

//--- design/capture_top.sv
// motor-current capture path, top level
// write decoder, axis channels, feedback mux and capture buffer

`include "capture_defines.svh"

module capture_top
    import capture_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    // register bus
    input  logic [15:0]                reg_waddr,
    input  logic [31:0]                reg_wdata,
    input  logic                       reg_wen,
    input  logic [15:0]                reg_raddr,
    output logic [31:0]                reg_rdata,
    output logic                       reg_rwait,
    // axes
    input  logic [`NUM_AXES-1:0]       adc_done,
    input  logic [`NUM_AXES-1:0][15:0] adc_data,
    output logic [`NUM_AXES-1:0][15:0] dac_setpoint,
    // timestamp and buffer status
    input  logic [31:0]                ts,
    output logic [15:0]                databuf_status
);

    logic [`NUM_AXES-1:0]       set_wen;
    logic [15:0]                set_value;
    logic [`NUM_AXES-1:0]       fb_pulse;
    logic [`NUM_AXES-1:0][15:0] fb_sample;
    axis_t                      chan;
    logic                       sel_pulse;
    logic [15:0]                sel_sample;

    dac_cmd_if cmd_if ();

    cmd_decoder decoder_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .set_wen   (set_wen),
        .set_value (set_value),
        .cmd       (cmd_if.src)
    );

    // channel i is bus axis i+1
    for (genvar i = 0; i < `NUM_AXES; i++) begin : g_axis
        axis_channel axis_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .set_wen      (set_wen[i]),
            .set_value    (set_value),
            .adc_done     (adc_done[i]),
            .adc_data     (adc_data[i]),
            .dac_setpoint (dac_setpoint[i]),
            .fb_pulse     (fb_pulse[i]),
            .fb_sample    (fb_sample[i])
        );
    end

    feedback_select select_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .fb_pulse   (fb_pulse),
        .fb_sample  (fb_sample),
        .chan       (chan),
        .sel_pulse  (sel_pulse),
        .sel_sample (sel_sample)
    );

    data_buffer buffer_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .cmd            (cmd_if.dst),
        .sel_pulse      (sel_pulse),
        .sel_sample     (sel_sample),
        .ts             (ts),
        .chan           (chan),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (reg_rdata),
        .reg_rwait      (reg_rwait),
        .databuf_status (databuf_status)
    );

endmodule

//--- design/cmd_decoder.sv
// bus write decode for the dac control registers
// per-axis setpoint strobes and the commanded-current event

`include "capture_defines.svh"

module cmd_decoder
    import capture_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic                 reg_wen,
    output logic [`NUM_AXES-1:0] set_wen,
    output logic [15:0]          set_value,
    dac_cmd_if.src               cmd
);

    logic  ctrl_hit;    // write lands on a dac control register
    axis_t wr_axis;

    assign wr_axis  = reg_waddr[7:4];
    assign ctrl_hit = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN)
                      && (reg_waddr[3:0] == `OFF_DAC_CTRL);

    // strobes, channel i answers to bus axis i+1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            set_wen     <= '0;
            cmd.cmd_wen <= 1'b0;
        end else begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                set_wen[i] <= ctrl_hit && (wr_axis == axis_t'(i + 1));
            end
            cmd.cmd_wen <= ctrl_hit;    // board page and high axes too
        end
    end

    // payload, only looked at with a strobe
    always_ff @(posedge clk) begin
        if (ctrl_hit) begin
            set_value       <= reg_wdata[15:0];
            cmd.cmd_axis    <= wr_axis;
            cmd.cmd_collect <= reg_wdata[30];   // start/stop capture
            cmd.cmd_value   <= reg_wdata[15:0];
        end
    end

endmodule

//--- design/dac_cmd_if.sv
// commanded-current event from the write decoder to the capture buffer
// one-cycle strobe plus axis, collect bit and value

interface dac_cmd_if
    import capture_pkg::*;
();

    logic        cmd_wen;       // one cycle per dac control write
    axis_t       cmd_axis;
    logic        cmd_collect;   // bit 30 of the write
    logic [15:0] cmd_value;     // commanded current

    modport src (output cmd_wen, output cmd_axis, output cmd_collect, output cmd_value);
    modport dst (input cmd_wen, input cmd_axis, input cmd_collect, input cmd_value);

endinterface

//--- design/data_buffer.sv
// circular capture buffer for commanded and measured motor current
// start/stop control, entry build, write pointer, status and bus read mux

`include "capture_defines.svh"

module data_buffer
    import capture_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    dac_cmd_if.dst      cmd,
    input  logic        sel_pulse,      // feedback ready on chan
    input  logic [15:0] sel_sample,
    input  logic [31:0] ts,
    output axis_t       chan,           // captured axis
    input  logic [15:0] reg_raddr,
    output logic [31:0] reg_rdata,
    output logic        reg_rwait,
    output logic [15:0] databuf_status
);

    logic               collecting;
    logic               fb_pending;     // pulse that met a collect command
    logic               buf_wr;
    logic [`BUF_AW-1:0] buf_wr_addr;    // write pointer
    buf_entry_t         buf_wr_data;
    logic [31:0]        mem_rdata;
    logic               ts_over;
    logic               cmd_start;      // collect command while idle
    logic               cmd_own;        // command for the captured axis
    logic               fb_take;
    status_word_t       status;
    logic               rd_mem;         // registered read decode
    logic               rd_stat;
    read_word_u         rd_word;

    assign ts_over   = |ts[31:14];
    assign cmd_start = cmd.cmd_wen && !collecting && cmd.cmd_collect;
    assign cmd_own   = cmd.cmd_wen && (cmd.cmd_axis == chan);
    assign fb_take   = !cmd.cmd_wen && ((collecting && sel_pulse) || fb_pending);

    // ---------------------------------------------------------------------------
    // capture control and write pointer
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chan        <= axis_t'(1);
            collecting  <= 1'b0;
            buf_wr_addr <= '0;
            buf_wr      <= 1'b0;
            fb_pending  <= 1'b0;
        end else if (cmd.cmd_wen) begin
            if (cmd_start) begin
                chan        <= cmd.cmd_axis;   // new captured axis
                buf_wr_addr <= '0;
                collecting  <= 1'b1;
            end else if (cmd_own) begin
                buf_wr_addr <= buf_wr_addr + `BUF_AW'(cmd.cmd_collect);
                collecting  <= cmd.cmd_collect;
            end
            buf_wr <= cmd.cmd_collect;      // stop writes no entry
            if (cmd.cmd_collect && sel_pulse && collecting)
                fb_pending <= 1'b1;         // written on the next free cycle
        end else if (fb_take) begin
            buf_wr      <= 1'b1;
            buf_wr_addr <= buf_wr_addr + 1'b1;  // wraps
            fb_pending  <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
        end
    end

    // entry for the ram, command wins over feedback
    always_ff @(posedge clk) begin
        if (cmd.cmd_wen || fb_take) begin
            buf_wr_data.is_fb   <= !cmd.cmd_wen;
            buf_wr_data.ts_over <= ts_over;
            buf_wr_data.ts_low  <= ts[13:0];
            buf_wr_data.value   <= cmd.cmd_wen ? cmd.cmd_value : sel_sample;
        end
    end

    sample_ram ram_i (
        .clk   (clk),
        .wen   (buf_wr),
        .waddr (buf_wr_addr),
        .wdata (buf_wr_data),
        .raddr (reg_raddr[`BUF_AW-1:0]),   // upper window wraps
        .rdata (mem_rdata)
    );

    // ---------------------------------------------------------------------------
    // status and read path
    // ---------------------------------------------------------------------------
    always_comb begin
        status            = '0;
        status.collecting = collecting;
        status.chan       = chan;
        status.wr_addr    = buf_wr_addr;
    end

    assign databuf_status = status[15:0];

    // decode held one cycle to meet the ram data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_mem  <= 1'b0;
            rd_stat <= 1'b0;
        end else begin
            rd_mem  <= (reg_raddr[15:12] == `ADDR_DBUF) && !reg_raddr[11];
            rd_stat <= (reg_raddr[15:12] == `ADDR_DBUF) && (reg_raddr[11:0] == 12'h800);
        end
    end

    always_comb begin
        rd_word = '0;                   // unmapped reads give zero
        if (rd_mem)
            rd_word.entry = buf_entry_t'(mem_rdata);
        else if (rd_stat)
            rd_word.status = status;
    end

    assign reg_rdata = rd_word;
    assign reg_rwait = rd_mem;          // memory reads only

endmodule

//--- design/feedback_select.sv
// feedback mux in front of the capture buffer
// picks pulse and sample of the captured axis, one register stage

`include "capture_defines.svh"

module feedback_select
    import capture_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [`NUM_AXES-1:0]       fb_pulse,
    input  logic [`NUM_AXES-1:0][15:0] fb_sample,
    input  axis_t                      chan,
    output logic                       sel_pulse,
    output logic [15:0]                sel_sample
);

    logic        mux_pulse;
    logic [15:0] mux_sample;

    // chan is the bus axis, channel i sits on bus axis i+1
    always_comb begin
        mux_pulse  = 1'b0;  // out of range chan selects nothing
        mux_sample = '0;
        for (int i = 0; i < `NUM_AXES; i++) begin
            if (chan == axis_t'(i + 1)) begin
                mux_pulse  = fb_pulse[i];
                mux_sample = fb_sample[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            sel_pulse <= 1'b0;
        else
            sel_pulse <= mux_pulse;
    end

    always_ff @(posedge clk) begin
        sel_sample <= mux_sample;
    end

endmodule

//--- design/sample_ram.sv
// capture memory, 32 bits by 2**BUF_AW entries
// simple dual port, one write port and a registered read port

`include "capture_defines.svh"

module sample_ram (
    input  logic               clk,
    input  logic               wen,
    input  logic [`BUF_AW-1:0] waddr,
    input  logic [31:0]        wdata,
    input  logic [`BUF_AW-1:0] raddr,
    output logic [31:0]        rdata
);

    localparam int DEPTH = 1 << `BUF_AW;

    logic [31:0] mem [DEPTH];   // block ram

    always_ff @(posedge clk) begin
        if (wen)
            mem[waddr] <= wdata;
    end

    // a read of the address being written returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- dv/capture_tb.sv
// testbench for the motor-current capture path
// clock, reset, bus tasks, buffer model, stimulus per behavior and the checks

`include "capture_defines.svh"

module capture_tb
    import capture_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUF_DEPTH   = 1 << `BUF_AW;
    localparam int WRAP_EDGES  = 1100;
    localparam int CHUNK       = 100;     // wrap edges per timestamp value
    localparam int TEST_CYCLES = 2 * WRAP_EDGES + BUF_DEPTH + 500;
    localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

    logic                       clk;
    logic                       arst_n;
    logic [15:0]                reg_waddr;
    logic [31:0]                reg_wdata;
    logic                       reg_wen;
    logic [15:0]                reg_raddr;
    logic [31:0]                reg_rdata;
    logic                       reg_rwait;
    logic [`NUM_AXES-1:0]       adc_done;
    logic [`NUM_AXES-1:0][15:0] adc_data;
    logic [`NUM_AXES-1:0][15:0] dac_setpoint;
    logic [31:0]                ts;
    logic [15:0]                databuf_status;

    // buffer model
    logic                       m_collecting;
    axis_t                      m_chan;
    logic [`BUF_AW-1:0]         m_ptr;
    logic [31:0]                m_mem [BUF_DEPTH];
    bit                         m_valid [BUF_DEPTH];   // address holds an entry
    logic [`NUM_AXES-1:0][15:0] exp_setpoint;
    logic                       raddr_is_mem;
    logic                       rwait_exp;              // raddr_is_mem one clock back

    string  test_name;
    int     errors = 0;
    int     cycles = 0;
    integer seed;

    capture_top dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_wen        (reg_wen),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (reg_rdata),
        .reg_rwait      (reg_rwait),
        .adc_done       (adc_done),
        .adc_data       (adc_data),
        .dac_setpoint   (dac_setpoint),
        .ts             (ts),
        .databuf_status (databuf_status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // concurrent checks
    // ------------------------------------------------------------------------
    // memory window of the buffer space, 0x7000 up to 0x77ff
    assign raddr_is_mem = (reg_raddr >= {`ADDR_DBUF, 12'h000})
                          && (reg_raddr <= {`ADDR_DBUF, 12'h7ff});

    always @(posedge clk)
        rwait_exp <= raddr_is_mem;

    // setpoints move only on their own axis write
    setpoint_a: assert property (@(posedge clk) disable iff (!arst_n)
                                 dac_setpoint == exp_setpoint)
    else begin
        errors++;
        $display("Mismatch %s setpoint expected %h actual %h", test_name,
                 $sampled(exp_setpoint), $sampled(dac_setpoint));
    end

    // wait flag follows a memory address by one clock
    rwait_a: assert property (@(posedge clk) disable iff (!arst_n)
                              reg_rwait == rwait_exp)
    else begin
        errors++;
        $display("Mismatch %s rwait expected %b actual %b", test_name,
                 $sampled(rwait_exp), $sampled(reg_rwait));
    end

    // ------------------------------------------------------------------------
    // model of the buffer rules
    // ------------------------------------------------------------------------
    function automatic logic [31:0] make_entry(input logic is_fb, input logic [31:0] t,
                                               input logic [15:0] v);
        buf_entry_t e;
        e.is_fb   = is_fb;
        e.ts_over = (t[31:14] != '0);
        e.ts_low  = t[13:0];
        e.value   = v;
        return e;
    endfunction

    task automatic model_store(input logic [`BUF_AW-1:0] a, input logic [31:0] w);
        m_mem[a]   = w;
        m_valid[a] = 1'b1;
    endtask

    task automatic model_cmd(input axis_t axis, input logic collect, input logic [15:0] v);
        if (!m_collecting && collect) begin
            m_chan       = axis;        // start picks the axis
            m_ptr        = '0;
            m_collecting = 1'b1;
            model_store(m_ptr, make_entry(1'b0, ts, v));
        end else if (axis == m_chan) begin
            m_ptr        = m_ptr + collect;
            m_collecting = collect;
            if (collect)
                model_store(m_ptr, make_entry(1'b0, ts, v));
        end else if (collect) begin
            model_store(m_ptr, make_entry(1'b0, ts, v));  // pointer stays
        end
    endtask

    task automatic model_fb(input axis_t axis, input logic [15:0] v);
        if (m_collecting && axis == m_chan) begin
            m_ptr = m_ptr + 1'b1;       // wraps at the buffer depth
            model_store(m_ptr, make_entry(1'b1, ts, v));
        end
    endtask

    // ------------------------------------------------------------------------
    // bus and axis stimulus driven on the falling edge
    // ------------------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // lets in-flight entries land before the timestamp moves
    task automatic set_ts(input logic [31:0] t);
        idle(4);
        ts = t;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge clk);
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        @(negedge clk);
        data = reg_rdata;   // one clock of read latency
    endtask

    // setpoint shows two clocks after the write cycle
    task automatic dac_write(input axis_t axis, input logic collect, input logic [15:0] v);
        bus_write({`ADDR_MAIN, 4'h0, axis, `OFF_DAC_CTRL}, {1'b0, collect, 14'h0, v});
        model_cmd(axis, collect, v);
        @(negedge clk);
        if (axis >= 1 && axis <= `NUM_AXES)
            exp_setpoint[axis - 1] = v;
    endtask

    task automatic fb_edge(input axis_t axis, input logic [15:0] v, input int hold);
        adc_data[axis - 1] = v;
        adc_done[axis - 1] = 1'b1;
        model_fb(axis, v);
        repeat (hold) @(negedge clk);
        adc_done[axis - 1] = 1'b0;
        @(negedge clk);     // low cycle before the next edge
    endtask

    // edge timed so the feedback meets a collect command in the buffer
    task automatic fb_with_cmd(input logic [15:0] fb_v, input logic [15:0] cmd_v);
        axis_t axis;
        axis = m_chan;
        adc_data[axis - 1] = fb_v;
        adc_done[axis - 1] = 1'b1;
        @(negedge clk);
        adc_done[axis - 1] = 1'b0;
        dac_write(axis, 1'b1, cmd_v);
        model_fb(axis, fb_v);   // lands after the command entry
    endtask

    // ------------------------------------------------------------------------
    // read-back checks
    // ------------------------------------------------------------------------
    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s %s expected %h actual %h", test_name, what, exp, got);
        end
    endtask

    task automatic check_status();
        logic [31:0] got;
        read_word_u  exp;
        exp                   = '0;
        exp.status.collecting = m_collecting;
        exp.status.chan       = m_chan;
        exp.status.wr_addr    = m_ptr;
        bus_read(16'h7800, got);
        compare_word("status", exp, got);
        compare_word("databuf_status", {16'h0, exp.status[15:0]}, {16'h0, databuf_status});
    endtask

    task automatic check_entry(input logic [15:0] base, input int a);
        logic [31:0] got;
        if (m_valid[a]) begin
            bus_read(base + 16'(a), got);
            compare_word($sformatf("entry %h", base + 16'(a)), m_mem[a], got);
        end
    endtask

    task automatic check_buffer(input logic [15:0] base);
        for (int a = 0; a < BUF_DEPTH; a++)
            check_entry(base, a);
    endtask

    task automatic check_zero(input logic [15:0] addr);
        logic [31:0] got;
        bus_read(addr, got);
        compare_word($sformatf("read %h", addr), 32'h0, got);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        axis_t       ax;
        seed         = 32'hb8f6_fb36;
        arst_n       = 1'b0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        reg_raddr    = '0;
        adc_done     = '0;
        adc_data     = '0;
        ts           = '0;
        exp_setpoint = '0;
        m_collecting = 1'b0;
        m_chan       = axis_t'(1);      // reset value of chan
        m_ptr        = '0;
        test_name    = "reset";
        idle(4);
        arst_n = 1'b1;
        idle(1);

        check_status();
        bus_read(16'h7000, rd);         // only the wait flag matters here

        test_name = "setpoint";
        for (int a = 1; a <= `NUM_AXES; a++)
            dac_write(axis_t'(a), 1'b0, 16'($random(seed)));
        dac_write(axis_t'(0), 1'b0, 16'h1234);      // board page
        dac_write(axis_t'(9), 1'b0, 16'h5678);      // no channel there
        bus_write(16'h0024, 32'h0000_abcd);         // other register in the axis 2 page
        bus_write(16'h1020, 32'h0000_abcd);         // other space
        idle(3);
        check_status();

        test_name = "start";
        set_ts(32'h0000_2a51);
        dac_write(axis_t'(2), 1'b1, 16'h8c31);
        idle(3);
        check_status();
        check_buffer(16'h7000);

        test_name = "feedback";
        for (int n = 0; n < 24; n++) begin
            ax = axis_t'(1 + ($unsigned($random(seed)) % `NUM_AXES));
            set_ts(32'h0000_0100 + n);
            fb_edge(ax, 16'($random(seed)), 1);
        end
        fb_edge(axis_t'(2), 16'h0f0f, 6);          // held level gives one edge
        idle(4);
        check_status();
        check_buffer(16'h7000);
        check_buffer(16'h7400);                     // upper window aliases

        test_name = "wrap";
        for (int c = 0; c < WRAP_EDGES / CHUNK; c++) begin
            if (c % 2 == 1)
                set_ts(32'h0003_0000 + c);          // above 14 bits
            else
                set_ts(32'h0000_1000 + c);
            for (int n = 0; n < CHUNK; n++)
                fb_edge(axis_t'(2), 16'($random(seed)), 1);
        end
        set_ts(32'h0001_7fff);
        dac_write(axis_t'(3), 1'b1, 16'h3333);      // other axis writes at the same address
        dac_write(axis_t'(2), 1'b1, 16'h2222);      // own axis advances the pointer
        fb_with_cmd(16'($random(seed)), 16'h4444);
        idle(4);
        check_status();
        check_buffer(16'h7000);

        test_name = "stop";
        dac_write(axis_t'(2), 1'b0, 16'h0bad);
        for (int n = 0; n < 4; n++)
            fb_edge(axis_t'(2), 16'($random(seed)), 1);
        idle(4);
        check_status();
        for (int d = -2; d <= 2; d++)
            check_entry(16'h7000, (int'(m_ptr) + d) & (BUF_DEPTH - 1));

        test_name = "unmapped";
        check_zero(16'h7801);
        check_zero(16'h7c00);
        check_zero(16'h0000);
        check_zero(16'h6000);
        idle(2);

        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
